// File: common/adamnet_pkg.sv
package adamnet_pkg;

  typedef logic [15:0] addr_t;   // System memory address
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] sector_t; // Disk sector number

  localparam addr_t pcb_base_init = 16'hFEC0; // PCB location out of reset
  localparam int    pcb_size      = 4;
  localparam int    dcb_size      = 21;
  localparam int    num_dcb       = 15;
  localparam int    sector_bytes  = 512;
  localparam int    min_disk_len  = 1024;     // Disk transfers move at least 1 KB

  // PCB field offsets
  localparam logic [4:0] pcb_cmd_stat   = 5'd0;
  localparam logic [4:0] pcb_ba_lo      = 5'd1;
  localparam logic [4:0] pcb_ba_hi      = 5'd2;
  localparam logic [4:0] pcb_max_dcb    = 5'd3;

  // DCB field offsets, 10 to 15 are retry and spare bytes
  localparam logic [4:0] dcb_cmd_stat   = 5'd0;
  localparam logic [4:0] dcb_ba_lo      = 5'd1;
  localparam logic [4:0] dcb_ba_hi      = 5'd2;
  localparam logic [4:0] dcb_buf_len_lo = 5'd3;
  localparam logic [4:0] dcb_buf_len_hi = 5'd4;
  localparam logic [4:0] dcb_sec_num_0  = 5'd5; // Sector number, LSB first
  localparam logic [4:0] dcb_sec_num_1  = 5'd6;
  localparam logic [4:0] dcb_sec_num_2  = 5'd7;
  localparam logic [4:0] dcb_sec_num_3  = 5'd8;
  localparam logic [4:0] dcb_dev_num    = 5'd9;  // Upper nibble of device code
  localparam logic [4:0] dcb_add_code   = 5'd16; // Lower nibble of device code
  localparam logic [4:0] dcb_maxl_lo    = 5'd17;
  localparam logic [4:0] dcb_maxl_hi    = 5'd18;
  localparam logic [4:0] dcb_dev_type   = 5'd19;
  localparam logic [4:0] dcb_node_type  = 5'd20;

  localparam byte_t cmd_pcb_sync1  = 8'h01; // Sync Z80
  localparam byte_t cmd_pcb_sync2  = 8'h02; // Sync master 6801
  localparam byte_t cmd_status     = 8'h01;
  localparam byte_t cmd_soft_reset = 8'h02;
  localparam byte_t cmd_read       = 8'h04;
  localparam byte_t rsp_status     = 8'h80;
  localparam byte_t rsp_ack        = 8'h90;

  typedef enum logic {cb_pcb, cb_dcb} cb_sel_t;

  typedef enum logic [3:0] {
    st_init_pcb, st_init_dcb, st_mem_wait, st_idle, st_get_code,
    st_dispatch, st_dsk_node, st_dsk_cmd, st_report, st_fetch,
    st_fetch_cap, st_start, st_disk_wait
  } ctrl_state_t;

endpackage

// File: rtl/bus_snoop.sv
module bus_snoop (
  input  logic               clk_i,
  input  logic               reset,        // Active low
  input  logic               z80_wr,
  input  logic               z80_rd,
  input  adamnet_pkg::addr_t z80_addr,
  input  adamnet_pkg::byte_t z80_data_wr,
  input  logic               ctrl_idle,
  output logic               pcb_cmd_evt,
  output logic               dcb_cmd_evt,
  output logic [3:0]         dcb_dev,
  output adamnet_pkg::byte_t cmd_data
);
  import adamnet_pkg::*;

  addr_t      last_addr;
  logic       last_wr;
  addr_t      dcb_cmd_addr [num_dcb];  // Command byte of each DCB
  logic       dcb_hit;
  logic [3:0] hit_dev;
  logic       bus_changed;

  assign bus_changed = (z80_addr != last_addr) || (z80_wr != last_wr);

  always_comb begin
    dcb_hit = 1'b0;
    hit_dev = '0;
    for (int i = 0; i < num_dcb; i++) begin
      dcb_cmd_addr[i] = pcb_base_init + addr_t'(pcb_size + i * dcb_size);
      if (i > 0 && z80_addr == dcb_cmd_addr[i]) begin  // DCB 0 never dispatches
        dcb_hit = 1'b1;
        hit_dev = 4'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pcb_cmd_evt <= 1'b0;
    dcb_cmd_evt <= 1'b0;
    if (!reset) begin
      last_addr <= '1;
      last_wr   <= 1'b0;
    end else if (ctrl_idle && bus_changed) begin  // Busy engine drops the access
      last_addr   <= z80_addr;
      last_wr     <= z80_wr;
      cmd_data    <= z80_wr ? z80_data_wr : 8'hFF;  // A read reports FF
      dcb_dev     <= hit_dev;
      pcb_cmd_evt <= z80_wr && (z80_addr == pcb_base_init);
      dcb_cmd_evt <= (z80_wr || z80_rd) && dcb_hit;
    end
  end

endmodule

// File: rtl/cb_mem_port.sv
module cb_mem_port (
  input  logic                 clk_i,
  input  logic                 reset,      // Active low
  input  logic                 mem_req,
  input  logic                 mem_we,
  input  adamnet_pkg::cb_sel_t mem_sel,
  input  logic [3:0]           mem_dev,
  input  logic [4:0]           mem_off,
  input  adamnet_pkg::byte_t   mem_wdata,
  output logic                 mem_done,
  output adamnet_pkg::byte_t   mem_rdata,
  output adamnet_pkg::addr_t   ramb_addr,
  output logic                 ramb_wr,
  output logic                 ramb_rd,
  output adamnet_pkg::byte_t   ramb_dout,
  input  adamnet_pkg::byte_t   ramb_din,
  input  logic                 ramb_wr_ack,
  input  logic                 ramb_rd_ack
);
  import adamnet_pkg::*;

  addr_t dcb_addr;
  addr_t cb_addr;

  // DCBs sit right after the PCB, dcb_size bytes each
  assign dcb_addr = pcb_base_init + addr_t'(pcb_size) + addr_t'(mem_dev) * addr_t'(dcb_size);
  assign cb_addr  = ((mem_sel == cb_pcb) ? pcb_base_init : dcb_addr) + addr_t'(mem_off);

  always_ff @(posedge clk_i) begin
    mem_done <= 1'b0;
    if (!reset) begin
      ramb_wr <= 1'b0;
      ramb_rd <= 1'b0;
    end else if (mem_req) begin
      ramb_addr <= cb_addr;
      ramb_dout <= mem_wdata;
      ramb_wr   <= mem_we;
      ramb_rd   <= !mem_we;
    end else if ((ramb_wr && ramb_wr_ack) || (ramb_rd && ramb_rd_ack)) begin
      ramb_wr   <= 1'b0;
      ramb_rd   <= 1'b0;
      mem_done  <= 1'b1;
      if (ramb_rd) mem_rdata <= ramb_din;  // Valid with the acknowledge
    end
  end

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!reset)
    !(ramb_wr && ramb_rd));

  // Strobe holds until the memory answers
  a_wr_held: assert property (@(posedge clk_i) disable iff (!reset)
    (ramb_wr && !ramb_wr_ack) |=> ramb_wr);

endmodule

// File: disk/disk_reader.sv
module disk_reader (
  input  logic                 clk_i,
  input  logic                 reset,        // Active low
  input  logic                 rd_start,
  input  adamnet_pkg::addr_t   buf_addr,
  input  logic [15:0]          buf_len,
  input  adamnet_pkg::sector_t first_sector,
  output logic                 rd_done,
  output logic                 disk_busy,
  output adamnet_pkg::sector_t disk_sector,
  output logic                 disk_load,
  input  logic                 disk_sector_loaded,
  output logic [8:0]           disk_addr,
  output logic                 disk_flush,
  input  adamnet_pkg::byte_t   disk_data,
  output adamnet_pkg::addr_t   ramb_addr,
  output logic                 ramb_wr,
  output adamnet_pkg::byte_t   ramb_dout,
  input  logic                 ramb_wr_ack
);
  import adamnet_pkg::*;

  typedef enum logic [2:0] {rs_idle, rs_load, rs_next, rs_settle, rs_fetch, rs_write} rd_state_t;

  rd_state_t   state;
  sector_t     sector;      // Logical sector, before interleave
  logic [15:0] remaining;   // Bytes left from this sector on
  logic [9:0]  byte_cnt;    // Bytes done in this sector

  always_ff @(posedge clk_i) begin
    rd_done    <= 1'b0;
    disk_flush <= 1'b0;
    if (!reset) begin
      state     <= rs_idle;
      disk_busy <= 1'b0;
      disk_load <= 1'b0;
      ramb_wr   <= 1'b0;
    end else begin
      case (state)
        rs_idle: if (rd_start) begin
          ramb_addr <= buf_addr;
          remaining <= buf_len;
          sector    <= first_sector;
          disk_busy <= 1'b1;
          state     <= rs_load;
        end
        rs_load: begin
          // Interleave 0,5,2,7,4,1,6,3 is low bits times 5
          disk_sector <= {sector[31:3], 3'(sector[2:0] * 3'd5)};
          disk_load   <= 1'b1;
          if (disk_sector_loaded) begin
            disk_load <= 1'b0;
            byte_cnt  <= '0;
            state     <= rs_next;
          end
        end
        rs_next: begin
          if (byte_cnt < 10'(sector_bytes) && 16'(byte_cnt) < remaining) begin
            disk_addr <= byte_cnt[8:0];
            state     <= rs_settle;
          end else begin
            disk_flush <= 1'b1;  // Sector end
            if (16'(byte_cnt) < remaining) begin
              remaining <= remaining - 16'(sector_bytes);
              sector    <= sector + 32'd1;
              state     <= rs_load;
            end else begin
              rd_done   <= 1'b1;
              disk_busy <= 1'b0;
              state     <= rs_idle;
            end
          end
        end
        rs_settle: state <= rs_fetch;  // Covers a registered disk data path
        rs_fetch: begin
          ramb_dout <= disk_data;
          ramb_wr   <= 1'b1;
          state     <= rs_write;
        end
        rs_write: if (ramb_wr_ack) begin
          ramb_wr   <= 1'b0;
          ramb_addr <= ramb_addr + 16'd1;
          byte_cnt  <= byte_cnt + 10'd1;
          state     <= rs_next;
        end
        default: state <= rs_idle;
      endcase
    end
  end

  // Bytes reach memory only from a loaded sector, at the counted address
  a_in_sector: assert property (@(posedge clk_i) disable iff (!reset)
    ramb_wr |-> !disk_load && (10'(disk_addr) == byte_cnt));

endmodule

// File: rtl/adamnet_ctrl.sv
module adamnet_ctrl #(
  parameter int num_disks = 1
) (
  input  logic                  clk_i,
  input  logic                  reset,        // Active low
  input  logic                  pcb_cmd_evt,
  input  logic                  dcb_cmd_evt,
  input  logic [3:0]            dcb_dev,
  input  adamnet_pkg::byte_t    cmd_data,
  input  logic                  mem_done,
  input  adamnet_pkg::byte_t    mem_rdata,
  input  logic                  rd_done,
  input  logic [num_disks-1:0]  disk_present,
  output logic                  mem_req,
  output logic                  mem_we,
  output adamnet_pkg::cb_sel_t  mem_sel,
  output logic [3:0]            mem_dev,
  output logic [4:0]            mem_off,
  output adamnet_pkg::byte_t    mem_wdata,
  output logic                  rd_start,
  output adamnet_pkg::addr_t    buf_addr,
  output logic [15:0]           buf_len,
  output adamnet_pkg::sector_t  first_sector,
  output logic                  ctrl_idle,
  output logic                  adamnet_wait_n
);
  import adamnet_pkg::*;

  ctrl_state_t state, ret_state;  // ret_state is where st_mem_wait goes next
  logic [4:0]  step;              // Sub-step inside init, report and fetch
  logic [3:0]  dev;               // DCB being serviced
  byte_t       cmd;
  byte_t       rd_q;              // Last control-block byte read
  logic [3:0]  code_hi;
  logic [1:0]  disk_id;
  logic [15:0] msg_size;
  logic        is_block;
  logic [15:0] xfer_len;          // Length as the DCB holds it
  logic [3:0]  present_ext;

  assign present_ext    = 4'(disk_present);  // Missing drives read as absent
  assign ctrl_idle      = (state == st_idle);
  assign adamnet_wait_n = ctrl_idle;
  assign buf_len = (xfer_len < 16'(min_disk_len)) ? 16'(min_disk_len) : xfer_len;

  // One control-block access, then continue at ret
  task automatic issue(input logic we, input cb_sel_t sel, input logic [4:0] off,
                       input byte_t data, input logic [3:0] blk, input ctrl_state_t ret);
    mem_req   <= 1'b1;
    mem_we    <= we;
    mem_sel   <= sel;
    mem_off   <= off;
    mem_wdata <= data;
    mem_dev   <= blk;
    ret_state <= ret;
    state     <= st_mem_wait;
  endtask

  function automatic logic [4:0] fetch_off(input logic [2:0] idx);
    case (idx)
      3'd0:    fetch_off = dcb_ba_lo;
      3'd1:    fetch_off = dcb_ba_hi;
      3'd2:    fetch_off = dcb_buf_len_lo;
      3'd3:    fetch_off = dcb_buf_len_hi;
      3'd4:    fetch_off = dcb_sec_num_0;
      3'd5:    fetch_off = dcb_sec_num_1;
      3'd6:    fetch_off = dcb_sec_num_2;
      default: fetch_off = dcb_sec_num_3;
    endcase
  endfunction

  always_ff @(posedge clk_i) begin
    mem_req  <= 1'b0;
    rd_start <= 1'b0;
    if (!reset) begin
      state     <= st_init_pcb;   // Build the control blocks first
      ret_state <= st_idle;
      step      <= '0;
    end else begin
      case (state)
        st_init_pcb: begin
          step <= (step == 5'd2) ? 5'd0 : step + 5'd1;
          case (step)
            5'd0:    issue(1'b1, cb_pcb, pcb_ba_lo, pcb_base_init[7:0], 4'd0, st_init_pcb);
            5'd1:    issue(1'b1, cb_pcb, pcb_ba_hi, pcb_base_init[15:8], 4'd0, st_init_pcb);
            default: issue(1'b1, cb_pcb, pcb_max_dcb, 8'(num_dcb), 4'd0, st_init_dcb);
          endcase
        end
        st_init_dcb: begin  // Even step dev_num, odd step add_code
          step <= step + 5'd1;
          if (!step[0]) issue(1'b1, cb_dcb, dcb_dev_num, 8'h00, step[4:1], st_init_dcb);
          else issue(1'b1, cb_dcb, dcb_add_code, {4'h0, step[4:1]}, step[4:1],
                     (step == 5'(2 * num_dcb - 1)) ? st_idle : st_init_dcb);
        end
        st_mem_wait: if (mem_done) begin
          rd_q  <= mem_rdata;
          state <= ret_state;
        end
        st_idle: begin
          if (pcb_cmd_evt && (cmd_data == cmd_pcb_sync1 || cmd_data == cmd_pcb_sync2)) begin
            issue(1'b1, cb_pcb, pcb_cmd_stat, rsp_status | cmd_data, 4'd0, st_idle);
          end else if (dcb_cmd_evt) begin
            dev <= dcb_dev;
            cmd <= cmd_data;    // FF when the Z80 read the byte
            issue(1'b0, cb_dcb, dcb_dev_num, 8'h00, dcb_dev, st_get_code);
          end
        end
        st_get_code: begin
          code_hi <= rd_q[3:0];
          issue(1'b0, cb_dcb, dcb_add_code, 8'h00, dev, st_dispatch);
        end
        st_dispatch: begin
          step <= '0;
          case ({code_hi, rd_q[3:0]})
            8'h01: begin  // Keyboard, single character buffer
              msg_size <= 16'h0001;
              is_block <= 1'b0;
              state    <= (cmd == cmd_status || cmd == cmd_soft_reset) ? st_report : st_idle;
            end
            8'h04, 8'h05, 8'h06, 8'h07: begin
              disk_id <= rd_q[1:0];
              if (cmd[7]) issue(1'b1, cb_dcb, dcb_cmd_stat, rsp_status, dev, st_idle);
              else issue(1'b0, cb_dcb, dcb_node_type, 8'h00, dev, st_dsk_node);
            end
            default: issue(1'b1, cb_dcb, dcb_cmd_stat, 8'h00, dev, st_idle); // Unknown device
          endcase
        end
        st_dsk_node:  // Clear errors, flag a missing disk
          issue(1'b1, cb_dcb, dcb_node_type,
                {rd_q[7:4], 2'b00, present_ext[disk_id] ? 2'b00 : 2'b11}, dev, st_dsk_cmd);
        st_dsk_cmd: begin
          msg_size <= 16'h0400;   // Block device, 1 KB
          is_block <= 1'b1;
          case (cmd)
            cmd_status:     state <= st_report;
            cmd_soft_reset: issue(1'b1, cb_dcb, dcb_cmd_stat, rsp_status, dev, st_idle);
            cmd_read:       issue(1'b1, cb_dcb, dcb_cmd_stat, 8'h00, dev, st_fetch); // Busy
            default:        state <= st_idle;
          endcase
        end
        st_report: begin
          step <= step + 5'd1;
          case (step[1:0])
            2'd0:    issue(1'b1, cb_dcb, dcb_cmd_stat, rsp_status, dev, st_report);
            2'd1:    issue(1'b1, cb_dcb, dcb_maxl_lo, msg_size[7:0], dev, st_report);
            2'd2:    issue(1'b1, cb_dcb, dcb_maxl_hi, msg_size[15:8], dev, st_report);
            default: issue(1'b1, cb_dcb, dcb_dev_type, {7'd0, is_block}, dev, st_idle);
          endcase
        end
        st_fetch: issue(1'b0, cb_dcb, fetch_off(step[2:0]), 8'h00, dev, st_fetch_cap);
        st_fetch_cap: begin
          step <= step + 5'd1;
          case (step[2:0])
            3'd0:    buf_addr[7:0]   <= rd_q;
            3'd1:    buf_addr[15:8]  <= rd_q;
            3'd2:    xfer_len[7:0]   <= rd_q;
            3'd3:    xfer_len[15:8]  <= rd_q;
            default: first_sector    <= {rd_q, first_sector[31:8]}; // Shift in LSB first
          endcase
          state <= (step[2:0] == 3'd7) ? st_start : st_fetch;
        end
        st_start: begin
          rd_start <= 1'b1;
          state    <= st_disk_wait;
        end
        st_disk_wait: if (rd_done) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: rtl/adamnet_top.sv
module adamnet_top #(
  parameter int num_disks = 1
) (
  input  logic                       clk_i,
  input  logic                       adam_reset_pcb_n_i,
  input  logic                       z80_wr,
  input  logic                       z80_rd,
  input  adamnet_pkg::addr_t         z80_addr,
  input  adamnet_pkg::byte_t         z80_data_wr,
  output adamnet_pkg::addr_t         ramb_addr,   // Shared ADAM system memory
  output logic                       ramb_wr,
  output logic                       ramb_rd,
  output adamnet_pkg::byte_t         ramb_dout,
  input  adamnet_pkg::byte_t         ramb_din,
  input  logic                       ramb_wr_ack,
  input  logic                       ramb_rd_ack,
  input  logic [num_disks-1:0]       disk_present,
  output adamnet_pkg::sector_t       disk_sector,
  output logic                       disk_load,
  input  logic                       disk_sector_loaded,
  output logic [8:0]                 disk_addr,
  output logic                       disk_flush,
  input  adamnet_pkg::byte_t         disk_data,
  output logic                       adamnet_wait_n
);
  import adamnet_pkg::*;

  logic        pcb_cmd_evt, dcb_cmd_evt, ctrl_idle;
  logic [3:0]  dcb_dev, mem_dev;
  byte_t       cmd_data, mem_wdata, mem_rdata;
  logic        mem_req, mem_we, mem_done;
  cb_sel_t     mem_sel;
  logic [4:0]  mem_off;
  logic        rd_start, rd_done, disk_busy;
  addr_t       buf_addr;
  logic [15:0] buf_len;
  sector_t     first_sector;
  addr_t       cb_addr, dr_addr;              // Control-block port and disk reader sides
  logic        cb_wr, cb_rd, dr_wr;
  byte_t       cb_dout, dr_dout;

  bus_snoop bus_snoop_i (
    .clk_i, .reset(adam_reset_pcb_n_i), .z80_wr, .z80_rd, .z80_addr, .z80_data_wr,
    .ctrl_idle, .pcb_cmd_evt, .dcb_cmd_evt, .dcb_dev, .cmd_data
  );

  adamnet_ctrl #(.num_disks(num_disks)) adamnet_ctrl_i (
    .clk_i, .reset(adam_reset_pcb_n_i), .pcb_cmd_evt, .dcb_cmd_evt, .dcb_dev, .cmd_data,
    .mem_done, .mem_rdata, .rd_done, .disk_present, .mem_req, .mem_we, .mem_sel, .mem_dev,
    .mem_off, .mem_wdata, .rd_start, .buf_addr, .buf_len, .first_sector, .ctrl_idle,
    .adamnet_wait_n
  );

  cb_mem_port cb_mem_port_i (
    .clk_i, .reset(adam_reset_pcb_n_i), .mem_req, .mem_we, .mem_sel, .mem_dev, .mem_off,
    .mem_wdata, .mem_done, .mem_rdata, .ramb_addr(cb_addr), .ramb_wr(cb_wr), .ramb_rd(cb_rd),
    .ramb_dout(cb_dout), .ramb_din, .ramb_wr_ack, .ramb_rd_ack
  );

  disk_reader disk_reader_i (
    .clk_i, .reset(adam_reset_pcb_n_i), .rd_start, .buf_addr, .buf_len, .first_sector,
    .rd_done, .disk_busy, .disk_sector, .disk_load, .disk_sector_loaded, .disk_addr,
    .disk_flush, .disk_data, .ramb_addr(dr_addr), .ramb_wr(dr_wr), .ramb_dout(dr_dout),
    .ramb_wr_ack
  );

  // Disk reader owns the memory bus for a whole transfer
  assign ramb_addr = disk_busy ? dr_addr : cb_addr;
  assign ramb_wr   = disk_busy ? dr_wr   : cb_wr;
  assign ramb_rd   = disk_busy ? 1'b0    : cb_rd;   // Reader never reads memory
  assign ramb_dout = disk_busy ? dr_dout : cb_dout;

endmodule

// File: tb/adamnet_checker.sv
module adamnet_checker (
  input  logic                 clk_i,
  input  logic                 ramb_wr,
  input  logic                 ramb_wr_ack,
  input  adamnet_pkg::addr_t   ramb_addr,
  input  adamnet_pkg::byte_t   ramb_dout,
  input  logic                 disk_load,
  input  logic                 disk_sector_loaded,
  input  adamnet_pkg::sector_t disk_sector,
  input  logic                 disk_flush,
  input  logic                 adamnet_wait_n,
  input  logic                 evt_valid,   // One request from the testbench top
  input  adamnet_pkg::byte_t   evt_op,
  input  adamnet_pkg::addr_t   evt_addr,
  input  adamnet_pkg::byte_t   evt_data,
  output int                   error_count
);
  import adamnet_pkg::*;

  localparam byte_t op_end           = 8'h00;
  localparam byte_t op_preload       = 8'h01;
  localparam byte_t op_expect_byte   = 8'h04;
  localparam byte_t op_end_test      = 8'h05;
  localparam byte_t op_expect_sector = 8'h07;
  localparam byte_t op_expect_count  = 8'h08;
  localparam byte_t op_fail_note     = 8'h09;

  byte_t       shadow [0:65535];   // Memory as the DUT left it
  sector_t     sectors [$];        // Disk sectors in load order
  sector_t     cur_sector;
  sector_t     got_sector;
  logic [9:0]  offset = '0;        // Byte position inside the sector
  logic [15:0] copy_count = '0;
  logic        copy_active = 1'b0;
  int          flush_count = 0;    // Sector ends seen
  int          flush_expect;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  assign error_count = errors;

  initial begin
    for (int a = 0; a < 65536; a++) shadow[a[15:0]] = a[7:0] ^ a[15:8]; // Same fill as memory
  end

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  always @(posedge clk_i) begin
    if (ramb_wr && ramb_wr_ack) begin
      shadow[ramb_addr] = ramb_dout;
      if (copy_active) begin     // Disk byte, rule is sector low byte XOR address
        if (ramb_dout !== (cur_sector[7:0] ^ offset[7:0])) begin
          $display("mismatch at %0t: ramb_dout for disk byte %0d got %h expected %h",
                   $time, offset, ramb_dout, cur_sector[7:0] ^ offset[7:0]);
          count_error();
        end
        offset     = offset + 10'd1;
        copy_count = copy_count + 16'd1;
      end
    end
    if (disk_flush) flush_count++;  // One pulse per sector end
    if (disk_load && disk_sector_loaded) begin
      sectors.push_back(disk_sector);
      cur_sector  = disk_sector;
      offset      = '0;
      copy_active = 1'b1;
    end else if (adamnet_wait_n) begin
      copy_active = 1'b0;        // Engine back to idle ends the copy
    end
    if (evt_valid) begin
      case (evt_op)
        op_preload: shadow[evt_addr] = evt_data;
        op_expect_byte: if (shadow[evt_addr] !== evt_data) begin
          $display("mismatch at %0t: mem[%h] got %h expected %h",
                   $time, evt_addr, shadow[evt_addr], evt_data);
          count_error();
        end
        op_expect_sector: if (sectors.size() == 0) begin
          $display("no disk sector was loaded where sector %h was expected", evt_data);
          count_error();
        end else begin
          got_sector = sectors.pop_front();
          if (got_sector !== {24'h0, evt_data}) begin
            $display("mismatch at %0t: disk_sector got %h expected %h",
                     $time, got_sector, {24'h0, evt_data});
            count_error();
          end
        end
        op_expect_count: begin
          if (copy_count !== evt_addr) begin
            $display("mismatch at %0t: disk bytes copied got %0d expected %0d",
                     $time, copy_count, evt_addr);
            count_error();
          end
          // Every sector touched ends with a flush
          flush_expect = (int'(evt_addr) + sector_bytes - 1) / sector_bytes;
          if (flush_count != flush_expect) begin
            $display("mismatch at %0t: disk_flush pulses got %0d expected %0d",
                     $time, flush_count, flush_expect);
            count_error();
          end
          copy_count  = '0;
          flush_count = 0;
        end
        op_end_test: begin
          tests_run++;
          if (test_errors == 0) $display("test %0d: ok", evt_data);
          else $display("test %0d: %0d errors", evt_data, test_errors);
          if (test_errors != 0) tests_failed++;
          test_errors = 0;
        end
        op_fail_note: count_error();  // Timeout or bad input, already reported
        op_end: $display("summary: %0d tests run, %0d failed, %0d errors",
                         tests_run, tests_failed, errors);
        default: ;
      endcase
    end
  end

endmodule

// File: tb/tb_adamnet.sv
module tb_adamnet;
  import adamnet_pkg::*;

  localparam byte_t op_end           = 8'h00;
  localparam byte_t op_preload       = 8'h01;
  localparam byte_t op_z80_write     = 8'h02;
  localparam byte_t op_wait_idle     = 8'h03;
  localparam byte_t op_expect_byte   = 8'h04;
  localparam byte_t op_end_test      = 8'h05;
  localparam byte_t op_disk_present  = 8'h06;
  localparam byte_t op_expect_sector = 8'h07;
  localparam byte_t op_expect_count  = 8'h08;
  localparam byte_t op_fail_note     = 8'h09; // Never in the file, tells the checker
  localparam int    num_ops          = 128;
  localparam int    write_timeout    = 20;
  localparam int    idle_timeout     = 20000; // A 1 KB disk read fits easily

  logic        clk_i = 1'b0;
  logic        adam_reset_pcb_n_i;
  logic        z80_wr;
  logic        z80_rd;
  addr_t       z80_addr;
  byte_t       z80_data_wr;
  addr_t       ramb_addr;
  logic        ramb_wr;
  logic        ramb_rd;
  byte_t       ramb_dout;
  byte_t       ramb_din = 8'h00;
  logic        ramb_wr_ack = 1'b0;
  logic        ramb_rd_ack = 1'b0;
  logic [0:0]  disk_present;
  sector_t     disk_sector;
  logic        disk_load;
  logic        disk_flush;
  logic        disk_sector_loaded = 1'b0;
  logic [8:0]  disk_addr;
  byte_t       disk_data = 8'h00;
  logic        adamnet_wait_n;
  logic        evt_valid;       // Request to the checker
  byte_t       evt_op;
  addr_t       evt_addr;
  byte_t       evt_data;
  int          error_count;

  byte_t       mem [0:65535];   // ADAM system memory
  logic [31:0] ops [0:num_ops-1];
  logic [31:0] rng = 32'h3ca410b4;
  logic [1:0]  delay = 2'd0;    // Acknowledge delay still to go
  logic        pending = 1'b0;
  logic        acked = 1'b0;
  byte_t       loaded_lo = 8'h00; // Low byte of the sector in the drive
  logic [1:0]  load_cnt = 2'd0;

  always #4 clk_i = ~clk_i;

  adamnet_top #(.num_disks(1)) adamnet_top_i (
    .clk_i, .adam_reset_pcb_n_i, .z80_wr, .z80_rd, .z80_addr, .z80_data_wr,
    .ramb_addr, .ramb_wr, .ramb_rd, .ramb_dout, .ramb_din, .ramb_wr_ack, .ramb_rd_ack,
    .disk_present, .disk_sector, .disk_load, .disk_sector_loaded, .disk_addr,
    .disk_flush, .disk_data, .adamnet_wait_n
  );

  adamnet_checker adamnet_checker_i (
    .clk_i, .ramb_wr, .ramb_wr_ack, .ramb_addr, .ramb_dout, .disk_load,
    .disk_sector_loaded, .disk_sector, .disk_flush, .adamnet_wait_n, .evt_valid, .evt_op,
    .evt_addr, .evt_data, .error_count
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory with 0 to 3 cycles of acknowledge delay
  always @(negedge clk_i) begin
    ramb_wr_ack = 1'b0;
    ramb_rd_ack = 1'b0;
    if (acked) begin
      acked = 1'b0;               // Strobe drops the edge after the acknowledge
    end else if (ramb_wr || ramb_rd) begin
      if (!pending) begin
        rng     = xorshift32(rng);
        delay   = rng[1:0];
        pending = 1'b1;
      end
      if (delay == 2'd0) begin
        if (ramb_wr) mem[ramb_addr] = ramb_dout;
        else ramb_din = mem[ramb_addr];
        ramb_wr_ack = ramb_wr;
        ramb_rd_ack = ramb_rd;
        pending     = 1'b0;
        acked       = 1'b1;
      end else begin
        delay = delay - 2'd1;
      end
    end
  end

  // Disk drive, sector bytes are sector low byte XOR byte address
  always @(negedge clk_i) begin
    if (disk_sector_loaded) begin
      disk_sector_loaded = 1'b0;
    end else if (disk_load) begin
      if (load_cnt == 2'd3) begin
        loaded_lo          = disk_sector[7:0];
        disk_sector_loaded = 1'b1;
        load_cnt           = 2'd0;
      end else begin
        load_cnt = load_cnt + 2'd1;
      end
    end
    disk_data = loaded_lo ^ disk_addr[7:0];
  end

  task automatic send_event(input byte_t op, input addr_t addr, input byte_t data);
    evt_op    = op;
    evt_addr  = addr;
    evt_data  = data;
    evt_valid = 1'b1;
    @(negedge clk_i);
    evt_valid = 1'b0;
  endtask

  // Holds the write until the engine goes busy
  task automatic z80_write(input addr_t addr, input byte_t data, output logic ok);
    int cnt;
    cnt         = 0;
    z80_addr    = addr;
    z80_data_wr = data;
    z80_wr      = 1'b1;
    while (adamnet_wait_n && cnt < write_timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    ok = !adamnet_wait_n;
    if (!ok) $display("engine did not go busy after the Z80 write to %h", addr);
    z80_wr   = 1'b0;
    z80_addr = 16'h0000;            // Bus parked away from the control blocks
  endtask

  task automatic wait_idle(output logic ok);
    int cnt;
    cnt = 0;
    while (!adamnet_wait_n && cnt < idle_timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    ok = adamnet_wait_n;
    if (!ok) $display("engine still busy after %0d cycles", idle_timeout);
  endtask

  initial begin
    logic [31:0] word;
    byte_t       op;
    logic        ok;
    logic        running;
    int          idx;
    int          tests_seen;
    adam_reset_pcb_n_i = 1'b0;
    z80_wr             = 1'b0;
    z80_rd             = 1'b0;
    z80_addr           = 16'h0000;
    z80_data_wr        = 8'h00;
    disk_present       = 1'b0;
    evt_valid          = 1'b0;
    evt_op             = op_end;
    evt_addr           = 16'h0000;
    evt_data           = 8'h00;
    for (int a = 0; a < 65536; a++) mem[a[15:0]] = a[7:0] ^ a[15:8];
    $readmemh("tb/adamnet_input.txt", ops);
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    adam_reset_pcb_n_i = 1'b1;
    idx        = 0;
    tests_seen = 0;
    running    = 1'b1;
    while (running) begin
      word = ops[idx[6:0]];
      idx++;
      op   = word[31:24];
      ok   = 1'b1;
      case (op)
        op_end:          running = 1'b0;
        op_z80_write:    z80_write(word[23:8], word[7:0], ok);
        op_wait_idle:    wait_idle(ok);
        op_disk_present: disk_present = word[0];
        op_preload: begin
          mem[word[23:8]] = word[7:0];
          send_event(op, word[23:8], word[7:0]); // Checker keeps its own copy
        end
        op_end_test: begin
          tests_seen++;
          send_event(op, word[23:8], word[7:0]);
        end
        op_expect_byte, op_expect_sector, op_expect_count:
          send_event(op, word[23:8], word[7:0]);
        default: begin
          $display("unknown operation %h at entry %0d of the input file", word, idx - 1);
          ok = 1'b0;
        end
      endcase
      if (running && idx == num_ops) begin
        $display("input file ends without an end operation");
        ok = 1'b0;
      end
      if (!ok) begin
        send_event(op_fail_note, 16'h0000, 8'h00);
        running = 1'b0;
      end
    end
    if (tests_seen == 0) begin
      $display("no test was found in the input file");
      send_event(op_fail_note, 16'h0000, 8'h00);
    end
    send_event(op_end, 16'h0000, 8'h00);  // Closing count line
    if (error_count == 0) $display("test passed");
    else $display("test failed");
    $finish;
  end

endmodule

// File: tb/adamnet_input.txt
// One word per line, op_addr_data in hex. Ops 01 preload, 02 Z80 write, 03 wait idle,
// 04 expect byte, 05 end test, 06 disk_present, 07 expect sector, 08 expect count in addr, 00 end
03_0000_00
04_FEC1_C0
04_FEC2_FE
04_FEC3_0F
04_FED4_00
04_FEE9_01
04_FFF3_00
04_FFFA_0E
05_0000_01
// PCB sync commands
02_FEC0_01
03_0000_00
04_FEC0_81
02_FEC0_02
03_0000_00
04_FEC0_82
05_0000_02
// Keyboard STATUS in DCB 1
02_FED9_01
03_0000_00
04_FED9_80
04_FEEA_01
04_FEEB_00
04_FEEC_00
05_0000_03
// Disk STATUS in DCB 4, drive absent then present
06_0000_00
01_FF2C_A5
02_FF18_01
03_0000_00
04_FF18_80
04_FF2C_A3
04_FF29_00
04_FF2A_04
04_FF2B_01
06_0000_01
01_FF2C_F7
02_FF18_01
03_0000_00
04_FF2C_F0
05_0000_04
// Disk READ in DCB 5, buffer 4000, length 000A, sector 9
01_FF2E_00
01_FF2F_40
01_FF30_0A
01_FF31_00
01_FF32_09
01_FF33_00
01_FF34_00
01_FF35_00
01_4400_5A
02_FF2D_04
03_0000_00
04_FF2D_00
04_4000_0D
04_4001_0C
04_41FF_F2
04_4200_0A
04_43FF_F5
04_4400_5A
07_0000_0D
07_0000_0A
08_0400_00
05_0000_05
// Unknown device code 0F in DCB 6
01_FF52_0F
02_FF42_01
03_0000_00
04_FF42_00
05_0000_06
00_0000_00

// File: build.f
common/adamnet_pkg.sv
rtl/bus_snoop.sv
rtl/cb_mem_port.sv
disk/disk_reader.sv
rtl/adamnet_ctrl.sv
rtl/adamnet_top.sv
tb/adamnet_checker.sv
tb/tb_adamnet.sv

// File: run_sim.sh
#!/bin/sh
# Run from the project root
set -e

verilator --binary --timing --assert -f build.f --top-module tb_adamnet -Mdir obj_dir

./obj_dir/Vtb_adamnet > sim.log
cat sim.log

# Status of the search decides the script's exit code
grep -qx "test passed" sim.log
